/* all.f */
+incdir+common
common/serial_pkg.sv
common/slm_pkg.sv
src/reset_stretch.sv
uart/uart_rx.sv
uart/uart_tx.sv
spi/spi_master.sv
src/byte_pairer.sv
src/reply_fifo.sv
src/reply_sender.sv
src/holo_top.sv
test/tb_holo_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the holo_top testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project root"
  exit 1
fi

verilator --binary --timing -j 0 -Mdir obj_dir --top-module tb_holo_top -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_holo_top
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

echo "Simulation exited cleanly"
exit 0

/* test/tb_holo_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "holo_defs.svh"

module tb_holo_top;

  localparam int clks_per_bit = `HOLO_CLKS_PER_BIT;
  localparam int num_fixed = 6;
  localparam int num_rows = 10;
  // Two extra rows cover the three bytes of the mid-pair step
  localparam int cycle_limit = (num_rows + 2) * 30 * clks_per_bit + 1000;

  // Fixed part of the stimulus table
  localparam serial_pkg::byte_t fixed_addr [num_fixed] = '{8'h01, 8'hFF, 8'h00,
                                                           8'h3C, 8'hA5, 8'h7E};
  localparam serial_pkg::byte_t fixed_data [num_fixed] = '{8'h80, 8'h00, 8'hFF,
                                                           8'hC3, 8'h5A, 8'h81};
  localparam logic [15:0] fixed_resp [num_fixed] = '{16'hA55A, 16'h00FF, 16'hFF00,
                                                     16'h1234, 16'h8001, 16'hFFFF};

  // Mid-pair reset step
  localparam serial_pkg::byte_t mid_odd = 8'hEE;
  localparam serial_pkg::byte_t mid_addr = 8'h42;
  localparam serial_pkg::byte_t mid_data = 8'h99;
  localparam logic [15:0] mid_resp = 16'h5EC7;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic uart_rx_line;
  logic spi_sout;
  wire  o_uart_tx;
  wire  o_spi_sen;
  wire  o_spi_sck;
  wire  o_spi_sdat;
  wire  o_slm_reset_n;

  // One row of stimulus and expected values per pair
  serial_pkg::byte_t   addr_tab [num_rows];
  serial_pkg::byte_t   data_tab [num_rows];
  logic [15:0]         resp_tab [num_rows];
  slm_pkg::spi_frame_t exp_frame_tab [num_rows];
  serial_pkg::byte_t   exp_reply_tab [num_rows];

  // Observed traffic
  slm_pkg::spi_frame_t frame_q [$];
  serial_pkg::byte_t   reply_q [$];
  int                  starts;
  logic [15:0]         slave_resp;
  int                  cycle_count;

  holo_top u_dut (
    .i_sys_clk         (sys_clk),
    .i_reset_all_cmd_w (reset_all_cmd_w),
    .i_uart_rx         (uart_rx_line),
    .i_spi_sout        (spi_sout),
    .o_uart_tx         (o_uart_tx),
    .o_spi_sen         (o_spi_sen),
    .o_spi_sck         (o_spi_sck),
    .o_spi_sdat        (o_spi_sdat),
    .o_slm_reset_n     (o_slm_reset_n)
  );

  // 100 ns period
  always #50 sys_clk = ~sys_clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic fail_run;
    $display("Test failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      fail_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Drive point 5 ns after the edge
  task automatic next_cycle;
    @(posedge sys_clk);
    #5;
  endtask

  // Sample point 1 ns after the edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sys_clk);
    #1;
  endtask

  task automatic build_table;
    logic [31:0] rnd;
    rnd = 32'd57392;
    for (int i = 0; i < num_rows; i++) begin
      if (i < num_fixed) begin
        addr_tab[i] = fixed_addr[i];
        data_tab[i] = fixed_data[i];
        resp_tab[i] = fixed_resp[i];
      end else begin
        rnd = xorshift32(rnd);
        addr_tab[i] = rnd[31:24];
        data_tab[i] = rnd[23:16];
        resp_tab[i] = rnd[15:0];
      end
      // Earlier byte goes out first
      // Reply is the low response byte
      exp_frame_tab[i] = {addr_tab[i], data_tab[i]};
      exp_reply_tab[i] = resp_tab[i][7:0];
    end
  endtask

  // Host side 8N1 sender
  task automatic send_byte(input serial_pkg::byte_t value);
    next_cycle();
    uart_rx_line = 1'b0;
    repeat (clks_per_bit) next_cycle();
    // LSB first
    for (int i = 0; i < 8; i++) begin
      uart_rx_line = value[i];
      repeat (clks_per_bit) next_cycle();
    end
    uart_rx_line = 1'b1;
    repeat (clks_per_bit) next_cycle();
  endtask

  task automatic apply_reset;
    int waited;
    reset_all_cmd_w = 1'b1;
    repeat (16) next_cycle();
    // Outputs parked while the command is held
    check_value("o_spi_sen", 32'(o_spi_sen), 32'd1);
    check_value("o_spi_sck", 32'(o_spi_sck), 32'd0);
    check_value("o_spi_sdat", 32'(o_spi_sdat), 32'd0);
    check_value("o_uart_tx", 32'(o_uart_tx), 32'd1);
    check_value("o_slm_reset_n", 32'(o_slm_reset_n), 32'd0);
    reset_all_cmd_w = 1'b0;
    waited = 0;
    // Edges until the SLM pin releases
    while (o_slm_reset_n !== 1'b1 && waited < 4 * `HOLO_RESET_HOLD) begin
      @(posedge sys_clk);
      #1;
      waited = waited + 1;
    end
    check_value("o_slm_reset_n release cycles", waited, 32'(`HOLO_RESET_HOLD + 1));
  endtask

  // Frame idx and then its reply in order
  task automatic collect_pair(input slm_pkg::spi_frame_t exp_frame,
                              input serial_pkg::byte_t exp_reply, input int idx);
    while (frame_q.size() <= idx) @(posedge sys_clk);
    check_value("o_spi_sdat frame", 32'(frame_q[idx]), 32'(exp_frame));
    while (reply_q.size() <= idx) @(posedge sys_clk);
    check_value("o_uart_tx reply", 32'(reply_q[idx]), 32'(exp_reply));
    // Exactly one frame per pair
    check_value("o_spi_sen frames", starts, 32'(idx + 1));
  endtask

  ////////////////////
  // Models
  ////////////////////

  // SPI slave samples 1 ns after each edge
  initial begin
    logic [15:0] shift_out;
    logic [15:0] cap;
    logic        prev_sen;
    logic        prev_sck;
    logic        drive;
    int          nbits;
    spi_sout = 1'b0;
    prev_sen = 1'b1;
    prev_sck = 1'b0;
    shift_out = '0;
    cap = '0;
    nbits = 0;
    forever begin
      @(posedge sys_clk);
      #1;
      drive = 1'b0;
      if (prev_sen === 1'b1 && o_spi_sen === 1'b0) begin
        // Frame opens with the first response bit
        starts = starts + 1;
        shift_out = slave_resp;
        cap = '0;
        nbits = 0;
        drive = 1'b1;
      end else if (o_spi_sen === 1'b0 && prev_sck === 1'b0 && o_spi_sck === 1'b1) begin
        cap = {cap[14:0], o_spi_sdat};
        nbits = nbits + 1;
        shift_out = {shift_out[14:0], 1'b0};
        drive = 1'b1;
      end else if (prev_sen === 1'b0 && o_spi_sen === 1'b1) begin
        check_value("o_spi_sck rises per frame", nbits, 32'd16);
        frame_q.push_back(cap);
      end
      prev_sen = o_spi_sen;
      prev_sck = o_spi_sck;
      // Next bit settles while SCK is high
      if (drive) begin
        #4;
        spi_sout = shift_out[15];
      end
    end
  end

  // Host side 8N1 decoder on o_uart_tx
  initial begin
    serial_pkg::byte_t rx;
    rx = '0;
    forever begin
      @(posedge sys_clk);
      #1;
      if (o_uart_tx === 1'b0) begin
        wait_cycles(clks_per_bit / 2);
        if (o_uart_tx !== 1'b0) begin
          $display("start bit on o_uart_tx ended before mid-bit at %0t ns", $time);
          fail_run();
        end
        for (int i = 0; i < 8; i++) begin
          wait_cycles(clks_per_bit);
          rx[i] = o_uart_tx;
        end
        wait_cycles(clks_per_bit);
        if (o_uart_tx !== 1'b1) begin
          $display("stop bit on o_uart_tx was low at %0t ns", $time);
          fail_run();
        end
        reply_q.push_back(rx);
      end
    end
  end

  // Run limit
  always @(posedge sys_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: no finish within %0d clock cycles", cycle_limit);
      fail_run();
    end
  end

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    sys_clk = 1'b0;
    reset_all_cmd_w = 1'b1;
    uart_rx_line = 1'b1;
    slave_resp = '0;
    starts = 0;
    cycle_count = 0;
    build_table();
    apply_reset();

    for (int row = 0; row < num_rows; row++) begin
      slave_resp = resp_tab[row];
      send_byte(addr_tab[row]);
      // Lone address opens no frame
      check_value("o_spi_sen frames", starts, 32'(row));
      send_byte(data_tab[row]);
      collect_pair(exp_frame_tab[row], exp_reply_tab[row], row);
    end

    // Odd byte that the reset drops
    slave_resp = mid_resp;
    send_byte(mid_odd);
    check_value("o_spi_sen frames", starts, 32'(num_rows));
    apply_reset();
    send_byte(mid_addr);
    send_byte(mid_data);
    collect_pair({mid_addr, mid_data}, mid_resp[7:0], num_rows);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* src/holo_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "holo_defs.svh"

module holo_top (
  input  wire i_sys_clk,
  input  wire i_reset_all_cmd_w,
  input  wire i_uart_rx,
  input  wire i_spi_sout,
  output wire o_uart_tx,
  output wire o_spi_sen,
  output wire o_spi_sck,
  output wire o_spi_sdat,
  output wire o_slm_reset_n
);

  logic                core_reset;
  logic                rx_valid;
  serial_pkg::byte_t   rx_byte;
  logic                spi_start;
  slm_pkg::spi_frame_t spi_frame;
  logic                spi_done;
  serial_pkg::byte_t   spi_rx_byte;
  logic                fifo_empty;
  logic                fifo_rd_en;
  serial_pkg::byte_t   fifo_rd_data;

  ////////////////////
  // Reset
  ////////////////////

  reset_stretch u_reset_stretch (
    .sys_clk         (i_sys_clk),
    .reset_all_cmd_w (i_reset_all_cmd_w),
    .o_core_reset    (core_reset),
    .o_slm_reset_n   (o_slm_reset_n)
  );

  ////////////////////
  // Host to SLM
  ////////////////////

  uart_rx #(.clks_per_bit(`HOLO_CLKS_PER_BIT)) u_uart_rx (
    .sys_clk         (i_sys_clk),
    .reset_all_cmd_w (i_reset_all_cmd_w),
    .i_serial        (i_uart_rx),
    .o_valid         (rx_valid),
    .o_byte          (rx_byte)
  );

  byte_pairer u_byte_pairer (
    .sys_clk         (i_sys_clk),
    .reset_all_cmd_w (i_reset_all_cmd_w),
    .i_valid         (rx_valid),
    .i_byte          (rx_byte),
    .o_start         (spi_start),
    .o_frame         (spi_frame)
  );

  // Byte pairs arrive far slower than a frame
  // so a start never meets a busy master
  spi_master u_spi_master (
    .sys_clk      (i_sys_clk),
    .i_core_reset (core_reset),
    .i_start      (spi_start),
    .i_frame      (spi_frame),
    .i_sout       (i_spi_sout),
    .o_sen        (o_spi_sen),
    .o_sck        (o_spi_sck),
    .o_sdat       (o_spi_sdat),
    .o_busy       (),
    .o_done       (spi_done),
    .o_rx_byte    (spi_rx_byte)
  );

  ////////////////////
  // SLM to host
  ////////////////////

  // Full FIFO drops the reply inside the buffer
  reply_fifo #(.depth(`HOLO_FIFO_DEPTH)) u_reply_fifo (
    .sys_clk      (i_sys_clk),
    .i_core_reset (core_reset),
    .i_wr_en      (spi_done),
    .i_wr_data    (spi_rx_byte),
    .o_full       (),
    .i_rd_en      (fifo_rd_en),
    .o_rd_data    (fifo_rd_data),
    .o_empty      (fifo_empty)
  );

  reply_sender #(.clks_per_bit(`HOLO_CLKS_PER_BIT)) u_reply_sender (
    .sys_clk      (i_sys_clk),
    .i_core_reset (core_reset),
    .i_empty      (fifo_empty),
    .o_rd_en      (fifo_rd_en),
    .i_rd_data    (fifo_rd_data),
    .o_uart_tx    (o_uart_tx)
  );

endmodule

`default_nettype wire

/* src/reply_sender.sv */
`timescale 1ns/1ns
`default_nettype none

`include "holo_defs.svh"

module reply_sender #(
  parameter int clks_per_bit = `HOLO_CLKS_PER_BIT
) (
  input  wire                    sys_clk,
  input  wire                    i_core_reset,
  input  wire                    i_empty,
  output logic                   o_rd_en,
  input  wire serial_pkg::byte_t i_rd_data,
  output logic                   o_uart_tx
);

  slm_pkg::send_state_e state;
  logic                 tx_start;
  logic                 tx_active;

  always_ff @(posedge sys_clk) begin
    if (i_core_reset) begin
      state <= slm_pkg::SEND_IDLE;
    end else begin
      case (state)
        // Wait for data and a free transmitter
        slm_pkg::SEND_IDLE:   if (!i_empty && !tx_active) state <= slm_pkg::SEND_POP;
        slm_pkg::SEND_POP:    state <= slm_pkg::SEND_LAUNCH;
        default:              state <= slm_pkg::SEND_IDLE;
      endcase
    end
  end

  // Popped byte is on i_rd_data by the launch cycle
  assign o_rd_en  = (state == slm_pkg::SEND_POP);
  assign tx_start = (state == slm_pkg::SEND_LAUNCH);

  uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
    .sys_clk      (sys_clk),
    .i_core_reset (i_core_reset),
    .i_start      (tx_start),
    .i_byte       (i_rd_data),
    .o_active     (tx_active),
    .o_serial     (o_uart_tx)
  );

endmodule

`default_nettype wire

/* src/reply_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "holo_defs.svh"

module reply_fifo #(
  parameter int depth = `HOLO_FIFO_DEPTH
) (
  input  wire                    sys_clk,
  input  wire                    i_core_reset,
  input  wire                    i_wr_en,
  input  wire serial_pkg::byte_t i_wr_data,
  output logic                   o_full,
  input  wire                    i_rd_en,
  output serial_pkg::byte_t      o_rd_data,
  output logic                   o_empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  serial_pkg::byte_t mem [depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  count;
  logic              do_wr;
  logic              do_rd;

  // Overflow writes and underflow reads are dropped
  assign do_wr = i_wr_en & ~o_full;
  assign do_rd = i_rd_en & ~o_empty;

  assign o_full  = (count == cnt_w'(depth));
  assign o_empty = (count == '0);

  always_ff @(posedge sys_clk) begin
    if (i_core_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at depth
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(do_wr) - cnt_w'(do_rd);
    end
  end

  // Storage and read port
  always_ff @(posedge sys_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
    if (do_rd) begin
      o_rd_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

/* src/byte_pairer.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_pairer (
  input  wire                      sys_clk,
  input  wire                      reset_all_cmd_w,
  input  wire                      i_valid,
  input  wire serial_pkg::byte_t   i_byte,
  output logic                     o_start,
  output slm_pkg::spi_frame_t      o_frame
);

  // Set while an address byte waits for its data
  logic have_addr;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      have_addr <= 1'b0;
      o_start   <= 1'b0;
    end else begin
      o_start <= 1'b0;
      if (i_valid) begin
        have_addr <= ~have_addr;
        // Second byte of the pair
        o_start   <= have_addr;
      end
    end
  end

  // Older byte slides up into the address slot
  always_ff @(posedge sys_clk) begin
    if (i_valid) begin
      o_frame <= {o_frame[7:0], i_byte};
    end
  end

endmodule

`default_nettype wire

/* spi/spi_master.sv */
`timescale 1ns/1ns
`default_nettype none

`include "holo_defs.svh"

module spi_master (
  input  wire                     sys_clk,
  input  wire                     i_core_reset,
  input  wire                     i_start,
  input  wire slm_pkg::spi_frame_t i_frame,
  input  wire                     i_sout,
  output logic                    o_sen,
  output logic                    o_sck,
  output logic                    o_sdat,
  output logic                    o_busy,
  output logic                    o_done,
  output serial_pkg::byte_t       o_rx_byte
);

  localparam int half = `HOLO_SPI_HALF_PERIOD;
  localparam int div_w = $clog2(half + 1);

  slm_pkg::spi_state_e state;
  logic [div_w-1:0]    div_cnt;
  logic [3:0]          bit_cnt;
  slm_pkg::spi_frame_t tx_shreg;
  slm_pkg::spi_frame_t rx_shreg;

  always_ff @(posedge sys_clk) begin
    if (i_core_reset) begin
      state   <= slm_pkg::SPI_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      o_sen   <= 1'b1;
      o_sck   <= 1'b0;
      o_sdat  <= 1'b0;
      o_busy  <= 1'b0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        slm_pkg::SPI_IDLE: begin
          div_cnt <= '0;
          bit_cnt <= '0;
          // Starts while busy never reach here
          if (i_start) begin
            tx_shreg <= i_frame;
            o_sdat   <= i_frame[15];
            o_sen    <= 1'b0;
            o_busy   <= 1'b1;
            state    <= slm_pkg::SPI_SHIFT;
          end
        end
        slm_pkg::SPI_SHIFT: begin
          if (div_cnt == div_w'(half - 1)) begin
            div_cnt <= '0;
            o_sck   <= ~o_sck;
            if (!o_sck) begin
              // Rising SCK edge
              // SOUT sampled here
              rx_shreg <= {rx_shreg[14:0], i_sout};
            end else if (bit_cnt == 4'd15) begin
              state <= slm_pkg::SPI_FINISH;
            end else begin
              // Falling SCK edge
              // Next bit goes out while SCK is low
              bit_cnt  <= bit_cnt + 1'b1;
              tx_shreg <= {tx_shreg[14:0], 1'b0};
              o_sdat   <= tx_shreg[14];
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          // Deselect and report in the same cycle
          o_sen     <= 1'b1;
          o_sdat    <= 1'b0;
          o_busy    <= 1'b0;
          o_done    <= 1'b1;
          o_rx_byte <= rx_shreg[7:0];
          state     <= slm_pkg::SPI_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "holo_defs.svh"

module uart_tx #(
  parameter int clks_per_bit = `HOLO_CLKS_PER_BIT
) (
  input  wire                sys_clk,
  input  wire                i_core_reset,
  input  wire                i_start,
  input  wire serial_pkg::byte_t i_byte,
  output logic               o_active,
  output logic               o_serial
);

  localparam int cnt_w = $clog2(clks_per_bit);

  serial_pkg::uart_state_e state;
  logic [cnt_w-1:0]        clk_cnt;
  logic [2:0]              bit_idx;
  serial_pkg::byte_t       tx_byte;

  // End of the current bit period
  logic bit_end;
  assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));

  always_ff @(posedge sys_clk) begin
    if (i_core_reset) begin
      state    <= serial_pkg::UART_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      o_active <= 1'b0;
      o_serial <= 1'b1;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        serial_pkg::UART_IDLE: begin
          // Line idles high
          o_serial <= 1'b1;
          clk_cnt  <= '0;
          bit_idx  <= '0;
          if (i_start) begin
            tx_byte  <= i_byte;
            o_active <= 1'b1;
            state    <= serial_pkg::UART_START;
          end
        end
        serial_pkg::UART_START: begin
          o_serial <= 1'b0;
          if (bit_end) begin
            state <= serial_pkg::UART_DATA;
          end
        end
        serial_pkg::UART_DATA: begin
          // LSB first
          o_serial <= tx_byte[bit_idx];
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= serial_pkg::UART_STOP;
            end
          end
        end
        default: begin
          o_serial <= 1'b1;
          // Release for the next byte
          if (bit_end) begin
            o_active <= 1'b0;
            state    <= serial_pkg::UART_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "holo_defs.svh"

module uart_rx #(
  parameter int clks_per_bit = `HOLO_CLKS_PER_BIT
) (
  input  wire                sys_clk,
  input  wire                reset_all_cmd_w,
  input  wire                i_serial,
  output logic               o_valid,
  output serial_pkg::byte_t  o_byte
);

  localparam int cnt_w = $clog2(clks_per_bit);

  serial_pkg::uart_state_e state;
  logic [cnt_w-1:0]        clk_cnt;
  logic [2:0]              bit_idx;
  logic [1:0]              rx_sync;

  // Two flops against metastability
  always_ff @(posedge sys_clk) begin
    rx_sync <= {rx_sync[0], i_serial};
  end

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state   <= serial_pkg::UART_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      o_valid <= 1'b0;
    end else begin
      // Valid is a single-cycle pulse
      o_valid <= 1'b0;
      case (state)
        serial_pkg::UART_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // Falling edge of start bit
          if (!rx_sync[1]) begin
            state <= serial_pkg::UART_START;
          end
        end
        serial_pkg::UART_START: begin
          // Recheck at mid-bit to reject glitches
          if (clk_cnt == cnt_w'((clks_per_bit - 1) / 2)) begin
            clk_cnt <= '0;
            state   <= rx_sync[1] ? serial_pkg::UART_IDLE : serial_pkg::UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        serial_pkg::UART_DATA: begin
          if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
            clk_cnt         <= '0;
            // LSB first
            o_byte[bit_idx] <= rx_sync[1];
            bit_idx         <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= serial_pkg::UART_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          // Middle of stop bit, framing check
          if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
            clk_cnt <= '0;
            o_valid <= rx_sync[1];
            state   <= serial_pkg::UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/reset_stretch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "holo_defs.svh"

module reset_stretch (
  input  wire  sys_clk,
  input  wire  reset_all_cmd_w,
  output logic o_core_reset,
  output logic o_slm_reset_n
);

  localparam int hold = `HOLO_RESET_HOLD;
  localparam int cnt_w = $clog2(hold + 1);

  logic [cnt_w-1:0] hold_cnt;

  // Reload while commanded, then count down to zero
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt <= cnt_w'(hold);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // Held for the command plus the countdown
  assign o_core_reset = reset_all_cmd_w | (hold_cnt != '0);

  // SLM pin is active low, one register behind
  always_ff @(posedge sys_clk) begin
    o_slm_reset_n <= ~o_core_reset;
  end

endmodule

`default_nettype wire

/* common/slm_pkg.sv */
`default_nettype none

package slm_pkg;

  // Address in upper byte, data in lower byte
  typedef logic [15:0] spi_frame_t;

  // SPI master sequencing
  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_FINISH} spi_state_e;

  // Reply sender sequencing
  typedef enum logic [1:0] {SEND_IDLE, SEND_POP, SEND_LAUNCH} send_state_e;

endpackage

`default_nettype wire

/* common/serial_pkg.sv */
`default_nettype none

package serial_pkg;

  // One byte on the UART side
  typedef logic [7:0] byte_t;

  // Shared by receiver and transmitter
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

/* common/holo_defs.svh */
`ifndef HOLO_DEFS_SVH
`define HOLO_DEFS_SVH

////////////////////
// UART timing
////////////////////

// System clocks per UART bit
// 50 MHz over 115200 baud
`define HOLO_CLKS_PER_BIT 434

////////////////////
// SLM side
////////////////////

// System clocks per half SCK period
`define HOLO_SPI_HALF_PERIOD 2

// Reply FIFO entries
`define HOLO_FIFO_DEPTH 4

// Extra cycles of reset after the command drops
`define HOLO_RESET_HOLD 10

`endif
